//--- src/core_cfg_pkg.sv
package core_cfg_pkg;

    // Core-wide widths
    parameter int ADDR_WIDTH  = 32;
    parameter int INSTR_WIDTH = 32;

    // Instructions handed out per fetch group
    parameter int FETCH_WIDTH = 4;

    // Instruction words in one cache line
    parameter int LINE_WORDS = 4;

    // First fetch address after reset
    parameter logic [ADDR_WIDTH-1:0] RESET_PC = 32'h1c00_0000;

    typedef logic [ADDR_WIDTH-1:0] addr_t;

    typedef logic [INSTR_WIDTH-1:0] instr_t;

    // 128-bit line, word 0 at the lowest address
    typedef instr_t [LINE_WORDS-1:0] line_t;

endpackage

//--- src/frontend_pkg.sv
package frontend_pkg;

    // Block id as carried with each instruction, enough for 16 FTQ entries
    typedef logic [3:0] ftq_id_t;

    // Instructions in a fetch block, 1 to 4
    typedef logic [2:0] blk_len_t;

    // One fetch block as produced by PC generation and held in the FTQ
    typedef struct packed {
        core_cfg_pkg::addr_t start_pc;
        blk_len_t            length;
        logic                cross_line;
    } fetch_block_t;

    // One instruction handed to the instruction buffer
    typedef struct packed {
        logic                 valid;
        core_cfg_pkg::addr_t  pc;
        core_cfg_pkg::instr_t instr;
        ftq_id_t              ftq_id;
    } instr_slot_t;

    typedef instr_slot_t [core_cfg_pkg::FETCH_WIDTH-1:0] instr_group_t;

    // Fetch sequencer states
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT,
        HOLD
    } fetch_state_e;

endpackage

//--- src/fetch_pc_gen.sv
`timescale 1ns/1ns

module fetch_pc_gen (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       full_i,
    input  logic                       flush_i,
    input  core_cfg_pkg::addr_t        flush_pc_i,
    output frontend_pkg::fetch_block_t blk_o,
    output logic                       blk_valid_o
);

    core_cfg_pkg::addr_t pc_q;
    logic                page_end;

    // Four more words would run past the 4 KiB page
    assign page_end = pc_q[11:0] > 12'hff0;

    always_comb begin
        blk_o.start_pc = pc_q;
        if (page_end) begin
            // Words left up to the page boundary
            blk_o.length = frontend_pkg::blk_len_t'((12'h000 - pc_q[11:0]) >> 2);
        end else begin
            blk_o.length = 3'd4;
        end
        // A block cut at the page end always fits in its line
        blk_o.cross_line = (pc_q[3:2] != 2'b00) && !page_end;
    end

    // Write into the FTQ whenever there is room and no redirect
    assign blk_valid_o = !full_i && !flush_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= core_cfg_pkg::RESET_PC;
        end else if (flush_i) begin
            pc_q <= flush_pc_i;
        end else if (blk_valid_o) begin
            pc_q <= pc_q + {27'b0, blk_o.length, 2'b00};
        end
    end

    // Every written block carries at least one and at most four words
    a_blk_length: assert property (
        @(posedge clk) disable iff (!rst_n)
        blk_valid_o |-> (blk_o.length >= 3'd1) && (blk_o.length <= 3'd4)
    );

endmodule

//--- src/ftq_pointers.sv
`timescale 1ns/1ns

module ftq_pointers #(
    parameter int FTQ_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         push_i,
    input  logic                         accept_i,
    input  logic                         commit_i,
    input  logic                         flush_i,
    input  logic [$clog2(FTQ_DEPTH)-1:0] flush_id_i,
    output logic [$clog2(FTQ_DEPTH)-1:0] tail_o,
    output logic [$clog2(FTQ_DEPTH)-1:0] fetch_ptr_o,
    output logic                         head_valid_o,
    output logic                         full_o
);

    localparam int ID_W  = $clog2(FTQ_DEPTH);
    localparam int CNT_W = ID_W + 1;

    logic [ID_W-1:0]  commit_q;
    logic [ID_W-1:0]  fetch_q;
    logic [ID_W-1:0]  tail_q;
    logic [ID_W-1:0]  keep_end;
    logic [ID_W-1:0]  fetch_back;
    logic [CNT_W-1:0] dropped;
    logic [CNT_W-1:0] occ_q;
    logic [CNT_W-1:0] occ_d;
    logic [CNT_W-1:0] unf_q;
    logic [CNT_W-1:0] unf_d;

    // First slot after the youngest block that survives a flush
    assign keep_end = flush_id_i + 1'b1;

    // Dropped blocks are the unfetched ones plus any handed out after the kept id
    assign fetch_back = fetch_q - keep_end;
    assign dropped    = unf_q + CNT_W'(fetch_back);

    // occ spans commit pointer to tail and unf spans fetch pointer to tail
    always_comb begin
        occ_d = occ_q + CNT_W'(push_i) - CNT_W'(commit_i);
        unf_d = unf_q + CNT_W'(push_i) - CNT_W'(accept_i);
        if (flush_i) begin
            occ_d = occ_q - CNT_W'(commit_i) - dropped;
            unf_d = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            commit_q <= '0;
            fetch_q  <= '0;
            tail_q   <= '0;
            occ_q    <= '0;
            unf_q    <= '0;
        end else begin
            if (commit_i) begin
                commit_q <= commit_q + 1'b1;
            end
            if (flush_i) begin
                tail_q  <= keep_end;
                fetch_q <= keep_end;
            end else begin
                if (push_i) begin
                    tail_q <= tail_q + 1'b1;
                end
                if (accept_i) begin
                    fetch_q <= fetch_q + 1'b1;
                end
            end
            occ_q <= occ_d;
            unf_q <= unf_d;
        end
    end

    assign tail_o       = tail_q;
    assign fetch_ptr_o  = fetch_q;
    assign head_valid_o = unf_q != '0;
    assign full_o       = occ_q == CNT_W'(FTQ_DEPTH);

    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n) push_i |-> !full_o
    );

    a_no_commit_empty: assert property (
        @(posedge clk) disable iff (!rst_n) commit_i |-> occ_q != '0
    );

endmodule

//--- src/ftq.sv
`timescale 1ns/1ns

module ftq #(
    parameter int FTQ_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  frontend_pkg::fetch_block_t   blk_i,
    input  logic                         blk_valid_i,
    input  logic                         accept_i,
    input  logic                         commit_i,
    input  logic                         flush_i,
    input  logic [$clog2(FTQ_DEPTH)-1:0] flush_id_i,
    output logic                         full_o,
    output frontend_pkg::fetch_block_t   head_o,
    output logic [$clog2(FTQ_DEPTH)-1:0] head_id_o,
    output logic                         head_valid_o
);

    localparam int ID_W = $clog2(FTQ_DEPTH);

    frontend_pkg::fetch_block_t entries_q [FTQ_DEPTH];
    logic [ID_W-1:0]            tail;
    logic [ID_W-1:0]            fetch_ptr;

    ftq_pointers #(
        .FTQ_DEPTH(FTQ_DEPTH)
    ) u_ptrs (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (blk_valid_i),
        .accept_i    (accept_i),
        .commit_i    (commit_i),
        .flush_i     (flush_i),
        .flush_id_i  (flush_id_i),
        .tail_o      (tail),
        .fetch_ptr_o (fetch_ptr),
        .head_valid_o(head_valid_o),
        .full_o      (full_o)
    );

    // Write strobe is already qualified by full and flush
    always_ff @(posedge clk) begin
        if (blk_valid_i) begin
            entries_q[tail] <= blk_i;
        end
    end

    // Oldest block not yet handed to the IFU
    assign head_o    = entries_q[fetch_ptr];
    assign head_id_o = fetch_ptr;

endmodule

//--- src/ifu_fetch_fsm.sv
`timescale 1ns/1ns

module ifu_fetch_fsm #(
    parameter int FTQ_DEPTH = 8
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  frontend_pkg::fetch_block_t       head_i,
    input  logic [$clog2(FTQ_DEPTH)-1:0]     head_id_i,
    input  logic                             head_valid_i,
    output logic                             accept_o,
    input  logic                             flush_i,
    input  logic                             stall_i,
    output logic [1:0]                       icache_req_o,
    output core_cfg_pkg::addr_t [1:0]        icache_addr_o,
    input  logic [1:0]                       icache_valid_i,
    input  core_cfg_pkg::line_t [1:0]        icache_data_i,
    output core_cfg_pkg::line_t [1:0]        lines_o,
    output frontend_pkg::fetch_block_t       blk_o,
    output frontend_pkg::ftq_id_t            blk_id_o,
    output logic                             out_fire_o
);

    localparam int ID_W = $clog2(FTQ_DEPTH);

    frontend_pkg::fetch_state_e state_q;
    frontend_pkg::fetch_state_e state_d;
    frontend_pkg::fetch_block_t blk_q;
    logic [ID_W-1:0]            id_q;
    core_cfg_pkg::line_t [1:0]  lines_q;
    logic [1:0]                 pend_q;
    logic [1:0]                 pend_d;
    // Requests seen by the cache and not yet answered
    logic [1:0]                 cnt_q;
    logic [1:0]                 cnt_d;
    logic [1:0]                 got;
    logic                       start;
    logic                       fire;

    // Only responses for the current fetch are captured
    assign got = pend_q & icache_valid_i;

    // New fetch waits until answers to a flushed one have drained
    assign start = (state_q == frontend_pkg::IDLE) && head_valid_i
                   && (cnt_q == 2'd0) && !flush_i;

    assign fire = (state_q == frontend_pkg::HOLD) && !stall_i && !flush_i;

    always_comb begin
        state_d = state_q;
        pend_d  = pend_q & ~icache_valid_i;
        case (state_q)
            frontend_pkg::IDLE: begin
                if (start) begin
                    state_d = frontend_pkg::REQ;
                    pend_d  = {head_i.cross_line, 1'b1};
                end
            end
            frontend_pkg::REQ: begin
                state_d = frontend_pkg::WAIT;
            end
            frontend_pkg::WAIT: begin
                if (pend_d == 2'b00) begin
                    state_d = frontend_pkg::HOLD;
                end
            end
            frontend_pkg::HOLD: begin
                if (fire) begin
                    state_d = frontend_pkg::IDLE;
                end
            end
            default: begin
                state_d = frontend_pkg::IDLE;
            end
        endcase
        // Drop whatever is in progress
        if (flush_i) begin
            state_d = frontend_pkg::IDLE;
            pend_d  = 2'b00;
        end
    end

    // Cache takes the requests at the end of REQ
    always_comb begin
        cnt_d = cnt_q - 2'(icache_valid_i[0]) - 2'(icache_valid_i[1]);
        if (state_q == frontend_pkg::REQ) begin
            cnt_d = cnt_d + 2'd1 + 2'(blk_q.cross_line);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= frontend_pkg::IDLE;
            pend_q  <= 2'b00;
            cnt_q   <= 2'd0;
        end else begin
            state_q <= state_d;
            pend_q  <= pend_d;
            cnt_q   <= cnt_d;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            blk_q <= head_i;
            id_q  <= head_id_i;
        end
        for (int p = 0; p < 2; p++) begin
            if (got[p]) begin
                lines_q[p] <= icache_data_i[p];
            end
        end
    end

    // Held until the answer shows up
    assign icache_req_o     = pend_q & ~icache_valid_i;
    assign icache_addr_o[0] = {blk_q.start_pc[31:4], 4'b0000};
    assign icache_addr_o[1] = {blk_q.start_pc[31:4], 4'b0000} + 32'd16;

    assign lines_o    = lines_q;
    assign blk_o      = blk_q;
    assign blk_id_o   = frontend_pkg::ftq_id_t'(id_q);
    assign out_fire_o = fire;
    assign accept_o   = fire;

    // Second line is read only when the block spans two lines
    a_port1_cross: assert property (
        @(posedge clk) disable iff (!rst_n) icache_req_o[1] |-> blk_q.cross_line
    );

endmodule

//--- src/ifu_line_align.sv
`timescale 1ns/1ns

module ifu_line_align (
    input  core_cfg_pkg::line_t [1:0]   lines_i,
    input  frontend_pkg::fetch_block_t  blk_i,
    input  frontend_pkg::ftq_id_t       blk_id_i,
    input  logic                        fire_i,
    output frontend_pkg::instr_group_t  instr_o
);

    localparam int LW = core_cfg_pkg::LINE_WORDS;
    localparam int FW = core_cfg_pkg::FETCH_WIDTH;
    localparam int IDX_W = $clog2(2 * LW);

    logic [IDX_W-1:0] base;

    // Word offset of the first instruction inside line 0
    assign base = IDX_W'(blk_i.start_pc[3:2]);

    always_comb begin : align_comb
        logic [IDX_W-1:0] idx;
        for (int k = 0; k < FW; k++) begin
            idx = base + IDX_W'(k);
            // Words beyond line 0 come from the following line
            if (idx < IDX_W'(LW)) begin
                instr_o[k].instr = lines_i[0][idx[1:0]];
            end else begin
                instr_o[k].instr = lines_i[1][idx[1:0]];
            end
            instr_o[k].pc     = blk_i.start_pc + 32'(4 * k);
            instr_o[k].valid  = fire_i && (3'(k) < blk_i.length);
            instr_o[k].ftq_id = blk_id_i;
        end
    end

endmodule

//--- src/frontend.sv
`timescale 1ns/1ns

module frontend #(
    parameter int FTQ_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         rst_n,

    // Dual-port instruction cache
    output logic [1:0]                   icache_req_o,
    output core_cfg_pkg::addr_t [1:0]    icache_addr_o,
    input  logic [1:0]                   icache_valid_i,
    input  core_cfg_pkg::line_t [1:0]    icache_data_i,

    // Backend
    input  logic                         commit_i,
    input  logic                         flush_i,
    input  core_cfg_pkg::addr_t          flush_pc_i,
    input  logic [$clog2(FTQ_DEPTH)-1:0] flush_ftq_id_i,

    // Instruction buffer
    input  logic                         stall_i,
    output frontend_pkg::instr_group_t   instr_o
);

    localparam int ID_W = $clog2(FTQ_DEPTH);

    frontend_pkg::fetch_block_t new_blk;
    logic                       new_blk_valid;
    logic                       ftq_full;
    frontend_pkg::fetch_block_t head_blk;
    logic [ID_W-1:0]            head_id;
    logic                       head_valid;
    logic                       accept;
    core_cfg_pkg::line_t [1:0]  fetched_lines;
    frontend_pkg::fetch_block_t ifu_blk;
    frontend_pkg::ftq_id_t      ifu_blk_id;
    logic                       ifu_fire;

    fetch_pc_gen u_pc_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .full_i     (ftq_full),
        .flush_i    (flush_i),
        .flush_pc_i (flush_pc_i),
        .blk_o      (new_blk),
        .blk_valid_o(new_blk_valid)
    );

    ftq #(
        .FTQ_DEPTH(FTQ_DEPTH)
    ) u_ftq (
        .clk         (clk),
        .rst_n       (rst_n),
        .blk_i       (new_blk),
        .blk_valid_i (new_blk_valid),
        .accept_i    (accept),
        .commit_i    (commit_i),
        .flush_i     (flush_i),
        .flush_id_i  (flush_ftq_id_i),
        .full_o      (ftq_full),
        .head_o      (head_blk),
        .head_id_o   (head_id),
        .head_valid_o(head_valid)
    );

    ifu_fetch_fsm #(
        .FTQ_DEPTH(FTQ_DEPTH)
    ) u_fetch_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .head_i        (head_blk),
        .head_id_i     (head_id),
        .head_valid_i  (head_valid),
        .accept_o      (accept),
        .flush_i       (flush_i),
        .stall_i       (stall_i),
        .icache_req_o  (icache_req_o),
        .icache_addr_o (icache_addr_o),
        .icache_valid_i(icache_valid_i),
        .icache_data_i (icache_data_i),
        .lines_o       (fetched_lines),
        .blk_o         (ifu_blk),
        .blk_id_o      (ifu_blk_id),
        .out_fire_o    (ifu_fire)
    );

    ifu_line_align u_line_align (
        .lines_i (fetched_lines),
        .blk_i   (ifu_blk),
        .blk_id_i(ifu_blk_id),
        .fire_i  (ifu_fire),
        .instr_o (instr_o)
    );

endmodule

//--- tb/icache_model.sv
`timescale 1ns/1ns

module icache_model (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [1:0]                req_i,
    input  core_cfg_pkg::addr_t [1:0] addr_i,
    output logic [1:0]                valid_o,
    output core_cfg_pkg::line_t [1:0] data_o
);

    logic [1:0]                busy_q;
    logic [2:0]                delay_q [2];
    core_cfg_pkg::addr_t [1:0] addr_q;

    // Each word holds its own address XOR a fixed pattern
    function automatic core_cfg_pkg::line_t line_at(input core_cfg_pkg::addr_t base);
        core_cfg_pkg::line_t line;
        for (int w = 0; w < core_cfg_pkg::LINE_WORDS; w++) begin
            line[w] = (base + 32'(4 * w)) ^ 32'h5a5a_5a5a;
        end
        return line;
    endfunction

    // Responses change on the falling edge, one request per port at a time
    always @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q  <= 2'b00;
            valid_o <= 2'b00;
            data_o  <= '0;
            addr_q  <= '0;
            delay_q <= '{3'd0, 3'd0};
        end else begin
            for (int p = 0; p < 2; p++) begin
                if (valid_o[p]) begin
                    valid_o[p] <= 1'b0;
                    busy_q[p]  <= 1'b0;
                end else if (busy_q[p]) begin
                    if (delay_q[p] == 3'd1) begin
                        valid_o[p] <= 1'b1;
                        data_o[p]  <= line_at(addr_q[p]);
                    end else begin
                        delay_q[p] <= delay_q[p] - 3'd1;
                    end
                end else if (req_i[p]) begin
                    // Answer after 1 to 4 cycles
                    busy_q[p]  <= 1'b1;
                    addr_q[p]  <= addr_i[p];
                    delay_q[p] <= 3'(($urandom % 4) + 1);
                end
            end
        end
    end

endmodule

//--- tb/tb_frontend.sv
`timescale 1ns/1ns

module tb_frontend;

    localparam int FTQ_DEPTH = 8;
    localparam int ID_W = $clog2(FTQ_DEPTH);
    localparam core_cfg_pkg::addr_t PATTERN = 32'h5a5a_5a5a;

    // Expected length of a block and the PC of the one after it
    typedef struct packed {
        logic [2:0]          length;
        core_cfg_pkg::addr_t next_pc;
    } block_ref_t;

    logic                       clk;
    logic                       rst_n;
    logic [1:0]                 icache_req;
    core_cfg_pkg::addr_t [1:0]  icache_addr;
    logic [1:0]                 icache_valid;
    core_cfg_pkg::line_t [1:0]  icache_data;
    logic                       commit;
    logic                       flush;
    core_cfg_pkg::addr_t        flush_pc;
    logic [ID_W-1:0]            flush_id;
    logic                       stall;
    frontend_pkg::instr_group_t instr;

    // Scoreboard state
    core_cfg_pkg::addr_t exp_pc;
    int                  exp_id;
    int                  last_id;
    int                  groups;
    int                  uncommitted;
    int                  value_errors;
    int                  timeout_errors;
    // 0 holds commit low, 1 commits at random, 2 commits whenever possible
    int                  commit_mode;
    logic                stall_on;

    frontend #(
        .FTQ_DEPTH(FTQ_DEPTH)
    ) dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .icache_req_o  (icache_req),
        .icache_addr_o (icache_addr),
        .icache_valid_i(icache_valid),
        .icache_data_i (icache_data),
        .commit_i      (commit),
        .flush_i       (flush),
        .flush_pc_i    (flush_pc),
        .flush_ftq_id_i(flush_id),
        .stall_i       (stall),
        .instr_o       (instr)
    );

    icache_model u_icache (
        .clk    (clk),
        .rst_n  (rst_n),
        .req_i  (icache_req),
        .addr_i (icache_addr),
        .valid_o(icache_valid),
        .data_o (icache_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Four words per block, fewer when the 4 KiB page ends first
    function automatic block_ref_t next_block(input core_cfg_pkg::addr_t pc);
        block_ref_t r;
        int         offset;
        offset = int'(pc[11:0]);
        if (offset > 'hff0) begin
            r.length = 3'((4096 - offset) / 4);
        end else begin
            r.length = 3'd4;
        end
        r.next_pc = pc + 32'(4 * int'(r.length));
        return r;
    endfunction

    function automatic logic any_valid(input frontend_pkg::instr_group_t g);
        logic v;
        v = 1'b0;
        for (int k = 0; k < core_cfg_pkg::FETCH_WIDTH; k++) begin
            v = v | g[k].valid;
        end
        return v;
    endfunction

    // Requests in flight belong to the block expected next
    task automatic check_requests();
        core_cfg_pkg::addr_t line_addr;
        line_addr = {exp_pc[31:4], 4'h0};
        if (icache_req[0]) begin
            assert (icache_addr[0] == line_addr) else begin
                $display("error: icache_addr_o[0] %h, expected %h", icache_addr[0], line_addr);
                value_errors++;
            end
        end
        if (icache_req[1]) begin
            assert (icache_addr[1] == line_addr + 32'h10) else begin
                $display("error: icache_addr_o[1] %h, expected %h", icache_addr[1],
                         line_addr + 32'h10);
                value_errors++;
            end
        end
    endtask

    task automatic check_group();
        block_ref_t          ref_blk;
        core_cfg_pkg::addr_t slot_pc;
        logic                exp_valid;
        ref_blk = next_block(exp_pc);
        for (int k = 0; k < core_cfg_pkg::FETCH_WIDTH; k++) begin
            slot_pc   = exp_pc + 32'(4 * k);
            exp_valid = k < int'(ref_blk.length);
            assert (instr[k].valid == exp_valid) else begin
                $display("error: instr_o[%0d].valid %h, expected %h", k, instr[k].valid,
                         exp_valid);
                value_errors++;
            end
            if (exp_valid) begin
                assert (instr[k].pc == slot_pc) else begin
                    $display("error: instr_o[%0d].pc %h, expected %h", k, instr[k].pc, slot_pc);
                    value_errors++;
                end
                assert (instr[k].instr == (slot_pc ^ PATTERN)) else begin
                    $display("error: instr_o[%0d].instr %h, expected %h", k, instr[k].instr,
                             slot_pc ^ PATTERN);
                    value_errors++;
                end
                assert (int'(instr[k].ftq_id) == exp_id) else begin
                    $display("error: instr_o[%0d].ftq_id %h, expected %h", k,
                             instr[k].ftq_id, exp_id);
                    value_errors++;
                end
            end
        end
        last_id     = exp_id;
        exp_pc      = ref_blk.next_pc;
        exp_id      = (exp_id + 1) % FTQ_DEPTH;
        groups      = groups + 1;
        uncommitted = uncommitted + 1;
    endtask

    // Output is stable just before the rising edge
    always @(posedge clk) begin
        if (rst_n) begin
            assert (!(stall && any_valid(instr))) else begin
                $display("error: instr_o slot valid while stall_i is high, stall_i %h", stall);
                value_errors++;
            end
            check_requests();
            if (commit) begin
                uncommitted = uncommitted - 1;
            end
            // Output in the flush cycle is ignored and fetch restarts after the kept id
            if (flush) begin
                exp_pc = flush_pc;
                exp_id = (int'(flush_id) + 1) % FTQ_DEPTH;
            end else if (any_valid(instr)) begin
                check_group();
            end
        end
    end

    task automatic step();
        @(negedge clk);
        flush = 1'b0;
        stall = stall_on && ($urandom % 3 == 0);
        if (commit_mode == 2) begin
            commit = uncommitted > 0;
        end else begin
            commit = (commit_mode == 1) && (uncommitted > 0) && ($urandom % 2 == 0);
        end
    endtask

    task automatic run_groups(input int n);
        int target;
        int cycles;
        target = groups + n;
        cycles = 0;
        while (groups < target && cycles < 1000) begin
            step();
            cycles++;
        end
        assert (groups >= target) else begin
            $display("Timed out waiting for fetch groups, %0d still missing", target - groups);
            timeout_errors++;
        end
    endtask

    // Redirect to pc and keep every block seen so far
    task automatic flush_to(input core_cfg_pkg::addr_t pc);
        @(negedge clk);
        flush    = 1'b1;
        flush_pc = pc;
        flush_id = ID_W'(last_id);
        commit   = 1'b0;
        stall    = 1'b0;
        step();
    endtask

    task automatic fill_without_commit();
        int cycles;
        int base;
        cycles = 0;
        commit_mode = 2;
        while (uncommitted != 0 && cycles < 500) begin
            step();
            cycles++;
        end
        assert (uncommitted == 0) else begin
            $display("Timed out committing the fetched blocks");
            timeout_errors++;
        end
        commit_mode = 0;
        base = groups;
        run_groups(FTQ_DEPTH);
        // The queue is full now and no further group may show up
        for (int i = 0; i < 80; i++) begin
            step();
        end
        assert (groups == base + FTQ_DEPTH) else begin
            $display("error: groups without commit %h, expected %h", groups - base, FTQ_DEPTH);
            value_errors++;
        end
    endtask

    initial begin
        void'($urandom(72200));
        rst_n          = 1'b0;
        commit         = 1'b0;
        flush          = 1'b0;
        flush_pc       = '0;
        flush_id       = '0;
        stall          = 1'b0;
        exp_pc         = core_cfg_pkg::RESET_PC;
        exp_id         = 0;
        last_id        = 0;
        groups         = 0;
        uncommitted    = 0;
        value_errors   = 0;
        timeout_errors = 0;
        commit_mode    = 1;
        stall_on       = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Sequential fetch from the reset PC
        run_groups(12);
        // Nonzero word offset so every block spans two lines
        flush_to(32'h1c00_1238);
        run_groups(8);
        // Blocks cut at the page end
        flush_to(32'h1c00_0ff4);
        run_groups(3);
        flush_to(32'h1c00_1ff8);
        run_groups(2);
        stall_on = 1'b1;
        run_groups(20);
        flush_to(32'h1c00_2a44);
        run_groups(10);
        stall_on = 1'b0;
        fill_without_commit();
        commit_mode = 1;
        run_groups(6);

        $display("errors: %0d value, %0d timeout", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- list.f
src/core_cfg_pkg.sv
src/frontend_pkg.sv
src/fetch_pc_gen.sv
src/ftq_pointers.sv
src/ftq.sv
src/ifu_fetch_fsm.sv
src/ifu_line_align.sv
src/frontend.sv
tb/icache_model.sv
tb/tb_frontend.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module tb_frontend -o sim_frontend

./obj_dir/sim_frontend | tee sim.log

if grep -q "All tests passed" sim.log; then
    exit 0
else
    exit 1
fi
